//--- design/rp_pkg.sv
package rp_pkg;

  //////////////////////////////////////////////////////////////////////
  // fast analog path
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned ADC_RAW_W = 16;  // raw ADC word, 2 reserved lsbs
  localparam int unsigned SAMPLE_W  = 14;  // converted sample width

  typedef logic signed [SAMPLE_W-1:0] sample_t;    // two's complement
  typedef logic        [SAMPLE_W-1:0] dac_code_t;  // unsigned, negative slope

  // both channels move together
  typedef struct packed {
    sample_t ch_a;
    sample_t ch_b;
  } sample_pair_t;

  //////////////////////////////////////////////////////////////////////
  // system bus
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned SYS_ADDR_W  = 32;
  localparam int unsigned SYS_DATA_W  = 32;
  localparam int unsigned NUM_REGIONS = 8;
  localparam int unsigned REGION_LSB  = 20;  // region field lsb
  localparam int unsigned REGION_MSB  = 22;  // region field msb

  typedef logic [REGION_MSB-REGION_LSB:0] region_t;

  typedef struct packed {
    logic [SYS_ADDR_W-1:0]   addr;   // byte address
    logic [SYS_DATA_W-1:0]   wdata;
    logic [SYS_DATA_W/8-1:0] sel;    // byte select
    logic                    wen;    // one cycle write strobe
    logic                    ren;    // one cycle read strobe
  } sys_req_t;

  typedef struct packed {
    logic [SYS_DATA_W-1:0] rdata;  // valid while ack
    logic                  err;
    logic                  ack;
  } sys_rsp_t;

  // housekeeping block
  localparam region_t                 HK_REGION   = 3'd0;
  localparam logic [SYS_DATA_W-1:0]   HK_ID_VALUE = 32'h5250_0a01;
  localparam logic [REGION_LSB-1:0]   HK_OFS_ID   = 20'h0_0000;
  localparam logic [REGION_LSB-1:0]   HK_OFS_LOOP = 20'h0_0004;
  localparam logic [REGION_LSB-1:0]   HK_OFS_LED  = 20'h0_0008;

endpackage

//--- design/adc_frontend.sv
`timescale 1ns/10ps

module adc_frontend (
  input  logic                           adc_clk,
  input  logic                           rst_i,
  input  logic [rp_pkg::ADC_RAW_W-1:0]   adc_dat_a_i,   // channel a, raw
  input  logic [rp_pkg::ADC_RAW_W-1:0]   adc_dat_b_i,   // channel b, raw
  input  logic                           loop_en_i,     // digital loop switch
  input  rp_pkg::sample_pair_t           loop_pair_i,   // dac side samples
  output rp_pkg::sample_pair_t           pair_o
);

  import rp_pkg::*;

  logic [SAMPLE_W-1:0] cap_a;  // captured negative slope code
  logic [SAMPLE_W-1:0] cap_b;
  sample_pair_t        conv_pair;

  //////////////////////////////////////////////////////////////////////
  // input capture
  //////////////////////////////////////////////////////////////////////

  // low 2 bits reserved on the 16 bit part, dropped here
  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
    begin
      cap_a <= '0;
      cap_b <= '0;
    end
    else
    begin
      cap_a <= adc_dat_a_i[ADC_RAW_W-1 -: SAMPLE_W];
      cap_b <= adc_dat_b_i[ADC_RAW_W-1 -: SAMPLE_W];
    end
  end

  // negative slope to two's complement, keep msb and flip the rest
  assign conv_pair.ch_a = sample_t'({cap_a[SAMPLE_W-1], ~cap_a[SAMPLE_W-2:0]});
  assign conv_pair.ch_b = sample_t'({cap_b[SAMPLE_W-1], ~cap_b[SAMPLE_W-2:0]});

  // loop source bypasses the converter, no extra register
  assign pair_o = loop_en_i ? loop_pair_i : conv_pair;

endmodule

//--- design/sample_delay_line.sv
`timescale 1ns/10ps

module sample_delay_line #(
  parameter int unsigned DELAY_DEPTH = 4  // stages, 1 or more
) (
  input  logic                  adc_clk,
  input  logic                  rst_i,
  input  rp_pkg::sample_pair_t  pair_i,
  output rp_pkg::sample_pair_t  pair_o
);

  import rp_pkg::*;

  sample_pair_t stage_q [DELAY_DEPTH];  // stage 0 nearest the input

  // plain shift, advances every cycle
  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
    begin
      for (int i = 0; i < DELAY_DEPTH; i++)
        stage_q[i] <= '0;
    end
    else
    begin
      stage_q[0] <= pair_i;
      for (int i = 1; i < DELAY_DEPTH; i++)
        stage_q[i] <= stage_q[i-1];
    end
  end

  assign pair_o = stage_q[DELAY_DEPTH-1];  // oldest pair

endmodule

//--- design/dac_backend.sv
`timescale 1ns/10ps

module dac_backend (
  input  logic                  adc_clk,
  input  logic                  rst_i,
  input  rp_pkg::sample_pair_t  pair_i,
  output rp_pkg::dac_code_t     dac_dat_a_o,  // channel a code
  output rp_pkg::dac_code_t     dac_dat_b_o,  // channel b code
  output logic                  dac_rst_o     // registered dac reset
);

  import rp_pkg::*;

  // code of a zero sample, what the path shows out of reset
  localparam dac_code_t DAC_RST_CODE = {1'b0, {(SAMPLE_W-1){1'b1}}};

  dac_code_t dac_a_q;
  dac_code_t dac_b_q;
  logic      dac_rst_q;

  //////////////////////////////////////////////////////////////////////
  // output registers
  //////////////////////////////////////////////////////////////////////

  // back to negative slope, same msb keep / low bits flip rule
  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
    begin
      dac_a_q <= DAC_RST_CODE;
      dac_b_q <= DAC_RST_CODE;
    end
    else
    begin
      dac_a_q <= {pair_i.ch_a[SAMPLE_W-1], ~pair_i.ch_a[SAMPLE_W-2:0]};
      dac_b_q <= {pair_i.ch_b[SAMPLE_W-1], ~pair_i.ch_b[SAMPLE_W-2:0]};
    end
  end

  // one cycle behind rst_i, so it outlasts reset by a cycle
  always_ff @(posedge adc_clk)
  begin
    dac_rst_q <= rst_i;
  end

  assign dac_dat_a_o = dac_a_q;
  assign dac_dat_b_o = dac_b_q;
  assign dac_rst_o   = dac_rst_q;

endmodule

//--- design/sys_bus_decoder.sv
`timescale 1ns/10ps

module sys_bus_decoder (
  input  logic              adc_clk,
  input  logic              rst_i,
  input  rp_pkg::sys_req_t  sys_req_i,  // from bus master
  output rp_pkg::sys_rsp_t  sys_rsp_o,  // back to bus master
  output rp_pkg::sys_req_t  hk_req_o,   // to housekeeping, strobes gated
  input  rp_pkg::sys_rsp_t  hk_rsp_i
);

  import rp_pkg::*;

  region_t                region;
  logic [NUM_REGIONS-1:0] region_sel;  // one hot
  logic                   strobe;
  sys_rsp_t               rsp_arr [NUM_REGIONS];

  //////////////////////////////////////////////////////////////////////
  // region select
  //////////////////////////////////////////////////////////////////////

  assign region     = sys_req_i.addr[REGION_MSB:REGION_LSB];
  assign region_sel = {{(NUM_REGIONS-1){1'b0}}, 1'b1} << region;
  assign strobe     = sys_req_i.wen | sys_req_i.ren;

  // address, data and sel pass through, strobes only into region 0
  always_comb
  begin
    hk_req_o     = sys_req_i;
    hk_req_o.wen = sys_req_i.wen & region_sel[HK_REGION];
    hk_req_o.ren = sys_req_i.ren & region_sel[HK_REGION];
  end

  //////////////////////////////////////////////////////////////////////
  // response mux
  //////////////////////////////////////////////////////////////////////

  // empty regions read zero, no error, ack in the strobe cycle
  always_comb
  begin
    for (int i = 0; i < NUM_REGIONS; i++)
    begin
      if (i == int'(HK_REGION))
        rsp_arr[i] = hk_rsp_i;
      else
      begin
        rsp_arr[i].rdata = '0;
        rsp_arr[i].err   = 1'b0;
        rsp_arr[i].ack   = strobe;
      end
    end
  end

  assign sys_rsp_o = rsp_arr[region];  // addr held until ack

endmodule

//--- design/hk_regs.sv
`timescale 1ns/10ps

module hk_regs (
  input  logic              adc_clk,
  input  logic              rst_i,
  input  rp_pkg::sys_req_t  req_i,      // strobes already region gated
  output rp_pkg::sys_rsp_t  rsp_o,
  output logic              loop_en_o,  // digital loop switch
  output logic [7:0]        led_o
);

  import rp_pkg::*;

  logic [REGION_LSB-1:0] ofs;       // offset inside the region
  logic                  wr_byte0;  // write hitting byte 0
  logic                  loop_q;
  logic [7:0]            led_q;
  logic                  ack_q;
  logic [SYS_DATA_W-1:0] rdata_q;
  logic [SYS_DATA_W-1:0] rd_mux;

  assign ofs      = req_i.addr[REGION_LSB-1:0];
  assign wr_byte0 = req_i.wen & req_i.sel[0];

  //////////////////////////////////////////////////////////////////////
  // control registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
    begin
      loop_q <= 1'b0;
      led_q  <= '0;
    end
    else if (wr_byte0)
    begin
      if (ofs == HK_OFS_LOOP)
        loop_q <= req_i.wdata[0];
      if (ofs == HK_OFS_LED)
        led_q <= req_i.wdata[7:0];  // unmapped offsets ignore the write
    end
  end

  //////////////////////////////////////////////////////////////////////
  // read path
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    case (ofs)
      HK_OFS_ID:   rd_mux = HK_ID_VALUE;
      HK_OFS_LOOP: rd_mux = {{(SYS_DATA_W-1){1'b0}}, loop_q};
      HK_OFS_LED:  rd_mux = {{(SYS_DATA_W-8){1'b0}}, led_q};
      default:     rd_mux = '0;  // hole reads zero
    endcase
  end

  // ack one cycle after either strobe
  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
      ack_q <= 1'b0;
    else
      ack_q <= req_i.wen | req_i.ren;
  end

  always_ff @(posedge adc_clk)
  begin
    if (req_i.ren)
      rdata_q <= rd_mux;  // lines up with ack
  end

  assign rsp_o.rdata = rdata_q;
  assign rsp_o.err   = 1'b0;
  assign rsp_o.ack   = ack_q;
  assign loop_en_o   = loop_q;
  assign led_o       = led_q;

endmodule

//--- design/rp_signal_top.sv
`timescale 1ns/10ps

module rp_signal_top #(
  parameter int unsigned DELAY_DEPTH = 4  // stages between adc and dac path
) (
  input  logic                          adc_clk,
  input  logic                          rst_i,
  // adc
  input  logic [rp_pkg::ADC_RAW_W-1:0]  adc_dat_a_i,
  input  logic [rp_pkg::ADC_RAW_W-1:0]  adc_dat_b_i,
  // system bus
  input  rp_pkg::sys_req_t              sys_req_i,
  output rp_pkg::sys_rsp_t              sys_rsp_o,
  // dac
  output rp_pkg::dac_code_t             dac_dat_a_o,
  output rp_pkg::dac_code_t             dac_dat_b_o,
  output logic                          dac_rst_o,
  // leds
  output logic [7:0]                    led_o
);

  import rp_pkg::*;

  sample_pair_t adc_pair;  // front end to delay line
  sample_pair_t dly_pair;  // delay line to dac, also the loop source
  sys_req_t     hk_req;
  sys_rsp_t     hk_rsp;
  logic         loop_en;

  //////////////////////////////////////////////////////////////////////
  // signal path
  //////////////////////////////////////////////////////////////////////

  adc_frontend i_adc_frontend (
    .adc_clk     (adc_clk),
    .rst_i       (rst_i),
    .adc_dat_a_i (adc_dat_a_i),
    .adc_dat_b_i (adc_dat_b_i),
    .loop_en_i   (loop_en),
    .loop_pair_i (dly_pair),   // closes the digital loop
    .pair_o      (adc_pair)
  );

  sample_delay_line #(
    .DELAY_DEPTH (DELAY_DEPTH)
  ) i_sample_delay_line (
    .adc_clk (adc_clk),
    .rst_i   (rst_i),
    .pair_i  (adc_pair),
    .pair_o  (dly_pair)
  );

  dac_backend i_dac_backend (
    .adc_clk     (adc_clk),
    .rst_i       (rst_i),
    .pair_i      (dly_pair),
    .dac_dat_a_o (dac_dat_a_o),
    .dac_dat_b_o (dac_dat_b_o),
    .dac_rst_o   (dac_rst_o)
  );

  //////////////////////////////////////////////////////////////////////
  // bus decode and housekeeping
  //////////////////////////////////////////////////////////////////////

  sys_bus_decoder i_sys_bus_decoder (
    .adc_clk   (adc_clk),
    .rst_i     (rst_i),
    .sys_req_i (sys_req_i),
    .sys_rsp_o (sys_rsp_o),
    .hk_req_o  (hk_req),
    .hk_rsp_i  (hk_rsp)
  );

  hk_regs i_hk_regs (
    .adc_clk   (adc_clk),
    .rst_i     (rst_i),
    .req_i     (hk_req),
    .rsp_o     (hk_rsp),
    .loop_en_o (loop_en),  // into the front end select
    .led_o     (led_o)
  );

endmodule

//--- dv/rp_signal_assertions.sv
`timescale 1ns/10ps

module rp_signal_assertions (
  input logic                           adc_clk,
  input logic                           rst_i,
  input logic [rp_pkg::NUM_REGIONS-1:0] region_sel_i,  // decoder select
  input rp_pkg::sys_req_t               sys_req_i,     // bus request, strobes ungated
  input rp_pkg::sys_rsp_t               hk_rsp_i,
  input logic                           dac_rst_i
);

  import rp_pkg::*;

  // exactly one region selected at any time
  region_onehot: assert property (@(posedge adc_clk) $onehot(region_sel_i))
    else $error("region select is not one hot: %b", region_sel_i);

  // housekeeping ack only one cycle after a bus strobe into region 0
  hk_ack_after_strobe: assert property (@(posedge adc_clk) disable iff (rst_i)
    hk_rsp_i.ack |-> $past((sys_req_i.wen | sys_req_i.ren)
                           && sys_req_i.addr[REGION_MSB:REGION_LSB] == HK_REGION))
    else $error("housekeeping ack without a region 0 strobe the cycle before");

  // dac reset register trails rst_i by one cycle
  dac_rst_follows: assert property (@(posedge adc_clk) rst_i |=> dac_rst_i)
    else $error("dac reset low in the cycle after reset");

endmodule

bind rp_signal_top rp_signal_assertions i_rp_signal_assertions (
  .adc_clk      (adc_clk),
  .rst_i        (rst_i),
  .region_sel_i (i_sys_bus_decoder.region_sel),
  .sys_req_i    (sys_req_i),
  .hk_rsp_i     (hk_rsp),
  .dac_rst_i    (dac_rst_o)
);

//--- dv/rp_signal_tb.sv
`timescale 1ns/10ps

module rp_signal_tb;

  import rp_pkg::*;

  localparam int unsigned DELAY_DEPTH = 4;
  localparam int PATH_CYCLES = 300;  // behavior 2 length
  localparam int HK_OPS      = 40;   // write plus read per op
  localparam int REG_OPS     = 40;
  localparam int LOOP_CYCLES = 80;
  localparam int TEST_CYCLES = 12 + PATH_CYCLES + 4 * HK_OPS + 2 * REG_OPS + 8
                             + 2 * LOOP_CYCLES + 8 + int'(DELAY_DEPTH) + 2;
  localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES + 100;

  // negative slope code of a zero sample, also the dac reset code
  localparam dac_code_t ZERO_CODE = {1'b0, {(SAMPLE_W-1){1'b1}}};

  typedef struct packed {
    dac_code_t a;
    dac_code_t b;
  } code_pair_t;

  logic                 adc_clk;
  logic                 rst;
  logic [ADC_RAW_W-1:0] adc_dat_a;
  logic [ADC_RAW_W-1:0] adc_dat_b;
  sys_req_t             sys_req;
  sys_rsp_t             sys_rsp;
  dac_code_t            dac_dat_a;
  dac_code_t            dac_dat_b;
  logic                 dac_rst;
  logic [7:0]           led;

  logic       nxt_rst;   // values for the next rising edge
  sys_req_t   nxt_req;
  integer     seed;
  int         cycle_cnt;
  int         code_errs;
  int         word_errs;
  int         bit_errs;
  string      test_name;
  logic       sh_loop;   // housekeeping shadow
  logic [7:0] sh_led;
  code_pair_t path_q[$];  // front end codes, oldest first, DELAY_DEPTH+1 deep

  rp_signal_top #(
    .DELAY_DEPTH (DELAY_DEPTH)
  ) i_rp_signal_top (
    .adc_clk     (adc_clk),
    .rst_i       (rst),
    .adc_dat_a_i (adc_dat_a),
    .adc_dat_b_i (adc_dat_b),
    .sys_req_i   (sys_req),
    .sys_rsp_o   (sys_rsp),
    .dac_dat_a_o (dac_dat_a),
    .dac_dat_b_o (dac_dat_b),
    .dac_rst_o   (dac_rst),
    .led_o       (led)
  );

  initial
  begin
    adc_clk = 1'b0;
    forever #10 adc_clk = ~adc_clk;  // 20 ns period
  end

  //////////////////////////////////////////////////////////////////////
  // compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic check_code(input string what, input dac_code_t exp, input dac_code_t act);
    if (act !== exp)
    begin
      code_errs++;
      $display("[ERROR] %s %s: expected %h, actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic check_word(input string what, input logic [SYS_DATA_W-1:0] exp,
                            input logic [SYS_DATA_W-1:0] act);
    if (act !== exp)
    begin
      word_errs++;
      $display("[ERROR] %s %s: expected %h, actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    if (act !== exp)
    begin
      bit_errs++;
      $display("[ERROR] %s %s: expected %b, actual %b", test_name, what, exp, act);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////

  // register write, only byte 0 of region 0 counts
  function automatic void hk_update(input sys_req_t req);
    if (req.wen && req.sel[0] && req.addr[REGION_MSB:REGION_LSB] == HK_REGION)
    begin
      if (req.addr[REGION_LSB-1:0] == HK_OFS_LOOP)
        sh_loop = req.wdata[0];
      else if (req.addr[REGION_LSB-1:0] == HK_OFS_LED)
        sh_led = req.wdata[7:0];
    end
  endfunction

  function automatic logic [SYS_DATA_W-1:0] hk_expect(input logic [REGION_LSB-1:0] ofs);
    if (ofs == HK_OFS_ID)
      return HK_ID_VALUE;
    else if (ofs == HK_OFS_LOOP)
      return {{(SYS_DATA_W-1){1'b0}}, sh_loop};
    else if (ofs == HK_OFS_LED)
      return {{(SYS_DATA_W-8){1'b0}}, sh_led};
    return '0;  // hole
  endfunction

  // one rising edge: drive, then model and check at the falling edge
  task automatic clock_step();
    sys_req_t             req_prev;
    logic                 rst_prev;
    logic [ADC_RAW_W-1:0] a_prev;
    logic [ADC_RAW_W-1:0] b_prev;
    code_pair_t           exp;
    code_pair_t           fe;
    @(posedge adc_clk);
    req_prev = sys_req;  // what the DUT samples at this edge
    rst_prev = rst;
    a_prev   = adc_dat_a;
    b_prev   = adc_dat_b;
    rst       <= nxt_rst;
    sys_req   <= nxt_req;
    adc_dat_a <= 16'($random(seed));
    adc_dat_b <= 16'($random(seed));
    @(negedge adc_clk);
    check_bit("dac reset", rst_prev, dac_rst);
    if (rst_prev)
    begin
      sh_loop = 1'b0;
      sh_led  = '0;
      path_q.delete();
      exp.a = ZERO_CODE;
      exp.b = ZERO_CODE;
      repeat (DELAY_DEPTH) path_q.push_back(exp);  // cleared delay stages
      fe = '0;                                     // capture register at 0
      path_q.push_back(fe);
    end
    else
    begin
      hk_update(req_prev);
      exp = path_q.pop_front();
      if (sh_loop)
        fe = path_q[0];  // code that left the delay line
      else
      begin
        fe.a = a_prev[ADC_RAW_W-1 -: SAMPLE_W];  // both conversions cancel
        fe.b = b_prev[ADC_RAW_W-1 -: SAMPLE_W];
      end
      path_q.push_back(fe);
    end
    check_code("dac a", exp.a, dac_dat_a);
    check_code("dac b", exp.b, dac_dat_b);
    check_word("led", {24'h0, sh_led}, {24'h0, led});
  endtask

  //////////////////////////////////////////////////////////////////////
  // bus access
  //////////////////////////////////////////////////////////////////////

  task automatic bus_access(input logic wr, input logic [SYS_ADDR_W-1:0] addr,
                            input logic [SYS_DATA_W-1:0] wdata, input logic [3:0] sel);
    logic hk_hit;
    hk_hit       = (addr[REGION_MSB:REGION_LSB] == HK_REGION);
    nxt_req.addr  = addr;
    nxt_req.wdata = wdata;
    nxt_req.sel   = sel;
    nxt_req.wen   = wr;
    nxt_req.ren   = ~wr;
    clock_step();  // strobe cycle
    if (hk_hit)
      check_bit("ack in strobe cycle", 1'b0, sys_rsp.ack);
    else
    begin
      check_bit("ack", 1'b1, sys_rsp.ack);  // same cycle for empty regions
      check_bit("err", 1'b0, sys_rsp.err);
      check_word("rdata", '0, sys_rsp.rdata);
    end
    nxt_req.wen = 1'b0;
    nxt_req.ren = 1'b0;
    clock_step();  // addr held
    check_bit("ack after strobe", hk_hit, sys_rsp.ack);
    if (hk_hit)
    begin
      check_bit("err", 1'b0, sys_rsp.err);
      if (!wr)
        check_word("rdata", hk_expect(addr[REGION_LSB-1:0]), sys_rsp.rdata);
    end
  endtask

  function automatic logic [SYS_ADDR_W-1:0] hk_addr(input logic [REGION_LSB-1:0] ofs);
    logic [31:0] rnd;
    rnd = $random(seed);
    return {rnd[31:23], HK_REGION, ofs};  // bits above the region are ignored
  endfunction

  //////////////////////////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES)
    begin
      @(posedge adc_clk);
      cycle_cnt++;
    end
    $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("SOME TESTS FAILED");
    $finish;
  end

  initial
  begin
    logic [31:0]           rnd;
    logic [REGION_LSB-1:0] ofs;
    region_t               region;
    seed      = 32'h700d7561;
    code_errs = 0;
    word_errs = 0;
    bit_errs  = 0;
    rst       = 1'b1;
    nxt_rst   = 1'b1;
    adc_dat_a = '0;
    adc_dat_b = '0;
    sys_req   = '0;
    nxt_req   = '0;
    sh_loop   = 1'b0;
    sh_led    = '0;

    test_name = "reset";
    repeat (3) clock_step();
    nxt_rst = 1'b0;
    clock_step();  // last edge with reset, dac reset stays one more cycle
    clock_step();
    check_word("led after reset", '0, {24'h0, led});
    bus_access(1'b0, hk_addr(HK_OFS_LOOP), '0, 4'hf);

    test_name = "signal path";
    repeat (PATH_CYCLES) clock_step();

    test_name = "housekeeping";
    for (int i = 0; i < HK_OPS; i++)
    begin
      rnd = $random(seed);
      ofs = rnd[0] ? HK_OFS_LED : HK_OFS_LOOP;
      bus_access(1'b1, hk_addr(ofs), $random(seed), rnd[7:4]);  // sel bit 0 random
      case (rnd[3:2])
        2'd0:    ofs = HK_OFS_ID;
        2'd1:    ofs = HK_OFS_LOOP;
        2'd2:    ofs = HK_OFS_LED;
        default: ofs = {rnd[27:12], 4'hc};  // never a mapped offset
      endcase
      bus_access(1'b0, hk_addr(ofs), '0, 4'hf);
    end

    test_name = "region decode";
    for (int i = 0; i < REG_OPS; i++)
    begin
      rnd    = $random(seed);
      region = 3'(1 + rnd[15:0] % 7);
      ofs    = 20'((rnd[23:16] % 3) * 4);  // mapped housekeeping offsets
      bus_access(rnd[31], {rnd[30:22], region, ofs}, $random(seed), 4'hf);
    end
    bus_access(1'b0, hk_addr(HK_OFS_LOOP), '0, 4'hf);
    bus_access(1'b0, hk_addr(HK_OFS_LED), '0, 4'hf);

    test_name = "digital loop";
    bus_access(1'b1, hk_addr(HK_OFS_LOOP), 32'h1, 4'h1);
    repeat (LOOP_CYCLES) clock_step();  // input ignored, codes recirculate
    bus_access(1'b1, hk_addr(HK_OFS_LOOP), 32'h0, 4'h1);
    bus_access(1'b0, hk_addr(HK_OFS_LOOP), '0, 4'hf);
    repeat (LOOP_CYCLES + DELAY_DEPTH + 2) clock_step();

    $display("errors: code %0d, word %0d, bit %0d", code_errs, word_errs, bit_errs);
    if (code_errs + word_errs + bit_errs == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

//--- rp_signal_top.f
design/rp_pkg.sv
design/adc_frontend.sv
design/sample_delay_line.sv
design/dac_backend.sv
design/sys_bus_decoder.sv
design/hk_regs.sv
design/rp_signal_top.sv
dv/rp_signal_assertions.sv
dv/rp_signal_tb.sv

//--- Makefile
VERILATOR  ?= verilator
FILELIST   ?= rp_signal_top.f
TB_TOP     ?= rp_signal_tb
RTL_TOP    ?= rp_signal_top
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
FAIL_MSG   ?= SOME TESTS FAILED
VFLAGS     ?= --timing --assert
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?= -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) $(SIM_FLAGS) --top-module $(TB_TOP) \
	  -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TB_TOP)
	./$(BUILD_DIR)/$(TB_TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
